// File: flist.f
hdl/riscv_isa_pkg.sv
hdl/r5p_ctl_pkg.sv
hdl/r5p_ctl_if.sv
hdl/r5p_ctl_fsm.sv
hdl/r5p_tmr.sv
hdl/r5p_alu.sv
hdl/r5p_lsu.sv
hdl/r5p_wbu.sv
hdl/r5p_wb_top.sv
verification/r5p_wb_props.sv
verification/r5p_wb_tb.sv

// File: hdl/r5p_alu.sv
`timescale 1ns/1ps
`default_nettype none

module r5p_alu
  import riscv_isa_pkg::*;
#(
  parameter int unsigned XLEN = 32
)(
  r5p_ctl_if.dat          ctl,
  output logic [XLEN-1:0] alu,  // Operation result
  output logic [XLEN-1:0] pcs   // PC increment
);

  logic [XLEN-1:0]        opa;  // rs1 or pc
  logic [XLEN-1:0]        opb;  // rs2 or imm
  fn3_t                   fn;
  logic                   sub;
  logic [4:0]             sha;  // Shift amount
  logic [XLEN-1:0]        srl;
  logic signed [XLEN-1:0] sra;

  // Operand selection
  assign opa = (ctl.opc == AUIPC) ? ctl.pc : ctl.rs1;
  assign opb = (ctl.opc == OP) ? ctl.rs2 : ctl.imm;
  assign fn  = (ctl.opc == AUIPC) ? ADD : ctl.fn3;  // AUIPC is an add

  assign sub = (ctl.opc == OP) && ctl.f7b5;  // SUB has no immediate form
  assign sha = opb[4:0];

  // Right shifts kept apart so the signed one stays signed
  assign srl = opa >> sha;
  assign sra = $signed(opa) >>> sha;

  always_comb begin
    case (fn)
      ADD    : alu = sub ? (opa - opb) : (opa + opb);
      SLL    : alu = opa << sha;
      SLT    : alu = XLEN'($signed(opa) < $signed(opb));
      SLTU   : alu = XLEN'(opa < opb);
      XOR    : alu = opa ^ opb;
      SR     : alu = ctl.f7b5 ? sra : srl;  // SRA or SRL
      OR     : alu = opa | opb;
      AND    : alu = opa & opb;
      default: alu = '0;
    endcase
  end

  assign pcs = ctl.pc + XLEN'(4);  // Link address for JAL/JALR

endmodule: r5p_alu

`default_nettype wire

// File: hdl/r5p_ctl_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module r5p_ctl_fsm
  import riscv_isa_pkg::*;
  import r5p_ctl_pkg::*;
#(
  parameter int unsigned XLEN = 32
)(
  input  wire logic            clk,
  input  wire logic            rst,
  // Command handshake
  input  wire logic            cmd_req,
  input  wire op32_op62_et     cmd_opc,
  input  wire fn3_t            cmd_fn3,
  input  wire logic            cmd_f7b5,
  input  wire gpr_adr_t        cmd_rd,
  input  wire logic [XLEN-1:0] cmd_rs1,
  input  wire logic [XLEN-1:0] cmd_rs2,
  input  wire logic [XLEN-1:0] cmd_imm,
  input  wire logic [XLEN-1:0] cmd_pc,
  output logic                 cmd_ack,
  output logic                 cmd_err,
  // Memory handshake
  output logic                 mem_req,
  input  wire logic            mem_ack,
  // Timeout counter
  output logic                 tmr_run,
  input  wire logic            tmr_exp,
  // Control bundle
  r5p_ctl_if.fsm               ctl
);

  fsm_state_et state;
  logic        cmd_smp;  // Command taken this edge
  logic        opc_ok;   // Supported opcode

  assign cmd_smp = (state == IDLE) && cmd_req;

  always_comb begin
    case (cmd_opc)
      LOAD, OP_IMM, AUIPC, OP, LUI, JALR, JAL: opc_ok = 1'b1;
      default:                                 opc_ok = 1'b0;
    endcase
  end

  ////////////////////
  // Command latch
  ////////////////////

  always_ff @(posedge clk) begin
    if (cmd_smp) begin
      ctl.opc  <= cmd_opc;
      ctl.fn3  <= cmd_fn3;
      ctl.f7b5 <= cmd_f7b5;
      ctl.rd   <= cmd_rd;
      ctl.rs1  <= cmd_rs1;
      ctl.rs2  <= cmd_rs2;
      ctl.imm  <= cmd_imm;
      ctl.pc   <= cmd_pc;
    end
  end

  ////////////////////
  // Sequencer
  ////////////////////

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      state   <= IDLE;
      cmd_err <= 1'b0;
    end else begin
      unique case (state)
        IDLE: if (cmd_req) begin
          if (!opc_ok) begin
            state   <= DONE;  // Reject straight away
            cmd_err <= 1'b1;
          end else if (cmd_opc == LOAD) begin
            state <= MREQ;
          end else begin
            state <= ISSUE;
          end
        end
        MREQ: if (mem_ack) begin
          state <= MREL;       // Data captured by LSU
        end else if (tmr_exp) begin
          state   <= DONE;     // Abandon the access
          cmd_err <= 1'b1;
        end
        MREL: if (!mem_ack) state <= ISSUE;
        ISSUE: state <= DONE;
        DONE: if (!cmd_req) begin
          state   <= IDLE;
          cmd_err <= 1'b0;
        end
      endcase
    end
  end

  assign cmd_ack = (state == DONE);
  assign mem_req = (state == MREQ);
  assign tmr_run = (state == MREQ);  // Count only while requesting

  assign ctl.iss = (state == ISSUE);
  assign ctl.ldv = (state == MREQ) && mem_ack;  // First ack cycle only

endmodule: r5p_ctl_fsm

`default_nettype wire

// File: hdl/r5p_ctl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface r5p_ctl_if
  import riscv_isa_pkg::*;
#(
  parameter int unsigned XLEN = 32
) ();

  op32_op62_et     opc;   // Latched opcode
  fn3_t            fn3;
  logic            f7b5;  // funct7 bit 5
  gpr_adr_t        rd;
  logic [XLEN-1:0] rs1;
  logic [XLEN-1:0] rs2;
  logic [XLEN-1:0] imm;
  logic [XLEN-1:0] pc;
  logic            iss;   // Issue strobe
  logic            ldv;   // Load data valid strobe

  modport fsm (output opc, fn3, f7b5, rd, rs1, rs2, imm, pc, iss, ldv);
  modport dat (input  opc, fn3, f7b5, rd, rs1, rs2, imm, pc, iss, ldv);

endinterface: r5p_ctl_if

`default_nettype wire

// File: hdl/r5p_ctl_pkg.sv
`default_nettype none

package r5p_ctl_pkg;

  // Sequencer states
  typedef enum logic [2:0] {
    IDLE,   // Wait for cmd_req
    ISSUE,  // One cycle, write-back registers load
    MREQ,   // Load request out, timer running
    MREL,   // Wait for mem_ack release
    DONE    // Hold cmd_ack until cmd_req drops
  } fsm_state_et;

  // Source of the write-back data
  typedef enum logic [2:0] {
    WB_NONE,
    WB_ALU,  // ALU result
    WB_PCS,  // PC + 4
    WB_IMM,  // Immediate
    WB_LSU   // Load data, bypassing tmp
  } wb_kind_et;

endpackage: r5p_ctl_pkg

`default_nettype wire

// File: hdl/r5p_lsu.sv
`timescale 1ns/1ps
`default_nettype none

module r5p_lsu
  import riscv_isa_pkg::*;
#(
  parameter int unsigned XLEN = 32
)(
  input  wire logic       clk,
  input  wire logic       rst,
  r5p_ctl_if.dat          ctl,
  // Memory side
  output logic [XLEN-1:0] mem_adr,    // Word address
  input  wire word_t      mem_rdata,
  // Load result
  output logic [XLEN-1:0] lsu
);

  logic [XLEN-1:0] adr;  // Effective byte address
  word_t           sh;   // Lane aligned to byte 0

  assign adr     = ctl.rs1 + ctl.imm;
  assign mem_adr = {adr[XLEN-1:2], 2'b00};

  // Move the addressed byte or half down
  assign sh = mem_rdata >> {adr[1:0], 3'b000};

  ////////////////////
  // Data capture
  ////////////////////

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      lsu <= '0;
    end else if (ctl.ldv) begin  // Held until the next load
      case (ctl.fn3)
        LB     : lsu <= XLEN'($signed(sh[7:0]));
        LH     : lsu <= XLEN'($signed(sh[15:0]));
        LBU    : lsu <= XLEN'(sh[7:0]);
        LHU    : lsu <= XLEN'(sh[15:0]);
        LW     : lsu <= XLEN'($signed(sh));  // Sign extends on 64 bits
        default: lsu <= XLEN'($signed(sh));
      endcase
    end
  end

endmodule: r5p_lsu

`default_nettype wire

// File: hdl/r5p_tmr.sv
`timescale 1ns/1ps
`default_nettype none

module r5p_tmr #(
  parameter int unsigned TMO_CYC = 16
)(
  input  wire logic clk,
  input  wire logic rst,
  input  wire logic run,  // Count enable, clears when low
  output logic      exp   // Limit reached
);

  localparam int unsigned CW = $clog2(TMO_CYC + 1);

  logic [CW-1:0] cnt;

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      cnt <= '0;
    end else if (!run) begin
      cnt <= '0;
    end else if (!exp) begin
      cnt <= cnt + 1'b1;  // Stop at the limit
    end
  end

  assign exp = (cnt == CW'(TMO_CYC));

endmodule: r5p_tmr

`default_nettype wire

// File: hdl/r5p_wb_top.sv
`timescale 1ns/1ps
`default_nettype none

module r5p_wb_top
  import riscv_isa_pkg::*;
#(
  parameter int unsigned XLEN    = 32,
  parameter int unsigned TMO_CYC = 16  // Load wait limit in cycles
)(
  input  wire logic            clk,
  input  wire logic            rst,
  // Command handshake
  input  wire logic            cmd_req,
  input  wire op32_op62_et     cmd_opc,
  input  wire fn3_t            cmd_fn3,
  input  wire logic            cmd_f7b5,
  input  wire gpr_adr_t        cmd_rd,
  input  wire logic [XLEN-1:0] cmd_rs1,
  input  wire logic [XLEN-1:0] cmd_rs2,
  input  wire logic [XLEN-1:0] cmd_imm,
  input  wire logic [XLEN-1:0] cmd_pc,
  output logic                 cmd_ack,
  output logic                 cmd_err,
  // Data memory handshake
  output logic                 mem_req,
  output logic [XLEN-1:0]      mem_adr,
  input  wire word_t           mem_rdata,
  input  wire logic            mem_ack,
  // GPR write
  output logic                 wen,
  output gpr_adr_t             adr,
  output logic [XLEN-1:0]      dat
);

  logic            tmr_run;
  logic            tmr_exp;
  logic [XLEN-1:0] alu;
  logic [XLEN-1:0] pcs;
  logic [XLEN-1:0] lsu;

  r5p_ctl_if #(.XLEN(XLEN)) ctl ();

  ////////////////////
  // Control
  ////////////////////

  r5p_ctl_fsm #(.XLEN(XLEN)) fsm0 (
    .clk, .rst,
    .cmd_req, .cmd_opc, .cmd_fn3, .cmd_f7b5, .cmd_rd,
    .cmd_rs1, .cmd_rs2, .cmd_imm, .cmd_pc,
    .cmd_ack, .cmd_err,
    .mem_req, .mem_ack,
    .tmr_run, .tmr_exp,
    .ctl    (ctl.fsm)
  );

  r5p_tmr #(.TMO_CYC(TMO_CYC)) tmr0 (
    .clk, .rst,
    .run (tmr_run),
    .exp (tmr_exp)
  );

  ////////////////////
  // Datapath
  ////////////////////

  r5p_alu #(.XLEN(XLEN)) alu0 (
    .ctl (ctl.dat),
    .alu, .pcs
  );

  r5p_lsu #(.XLEN(XLEN)) lsu0 (
    .clk, .rst,
    .ctl (ctl.dat),
    .mem_adr, .mem_rdata,
    .lsu
  );

  r5p_wbu #(.XLEN(XLEN)) wbu0 (
    .clk, .rst,
    .ctl (ctl.dat),
    .alu, .lsu, .pcs,
    .wen, .adr, .dat
  );

endmodule: r5p_wb_top

`default_nettype wire

// File: hdl/r5p_wbu.sv
`timescale 1ns/1ps
`default_nettype none

module r5p_wbu
  import riscv_isa_pkg::*;
  import r5p_ctl_pkg::*;
#(
  parameter int unsigned XLEN = 32
)(
  input  wire logic            clk,
  input  wire logic            rst,
  r5p_ctl_if.dat               ctl,
  // Result sources
  input  wire logic [XLEN-1:0] alu,
  input  wire logic [XLEN-1:0] lsu,
  input  wire logic [XLEN-1:0] pcs,
  // GPR write port
  output logic                 wen,
  output gpr_adr_t             adr,
  output logic [XLEN-1:0]      dat
);

  wb_kind_et       kind;  // Decoded from latched opcode
  wb_kind_et       sel;   // Registered kind
  logic [XLEN-1:0] tmp;   // Pre-multiplexed result

  always_comb begin
    case (ctl.opc)
      AUIPC, OP, OP_IMM: kind = WB_ALU;
      JAL, JALR:         kind = WB_PCS;
      LUI:               kind = WB_IMM;
      LOAD:              kind = WB_LSU;
      default:           kind = WB_NONE;
    endcase
  end

  ////////////////////
  // Issue registers
  ////////////////////

  always_ff @(posedge clk, posedge rst) begin
    if (rst) begin
      wen <= 1'b0;
      adr <= '0;
      sel <= WB_NONE;
    end else begin
      wen <= ctl.iss && (ctl.rd != '0);  // x0 never written, one cycle pulse
      if (ctl.iss) begin
        adr <= ctl.rd;
        sel <= kind;
      end
    end
  end

  // Pre multiplexer
  always_ff @(posedge clk) begin
    if (ctl.iss) begin
      case (kind)
        WB_ALU : tmp <= alu;
        WB_PCS : tmp <= pcs;
        WB_IMM : tmp <= ctl.imm;
        default: tmp <= '0;  // Load data comes through the bypass
      endcase
    end
  end

  // Output multiplexer
  always_comb begin
    case (sel)
      WB_LSU : dat = lsu;  // Already stable since ldv
      default: dat = tmp;
    endcase
  end

endmodule: r5p_wbu

`default_nettype wire

// File: hdl/riscv_isa_pkg.sv
`default_nettype none

package riscv_isa_pkg;

  // Major opcode, instruction bits [6:2]
  typedef enum logic [4:0] {
    LOAD   = 5'b00_000,
    OP_IMM = 5'b00_100,
    AUIPC  = 5'b00_101,
    OP     = 5'b01_100,
    LUI    = 5'b01_101,
    JALR   = 5'b11_001,
    JAL    = 5'b11_011
  } op32_op62_et;

  typedef logic [2:0]  fn3_t;      // funct3 field
  typedef logic [4:0]  gpr_adr_t;  // GPR index
  typedef logic [31:0] word_t;     // Memory data lane

  // ALU funct3 codes
  localparam fn3_t ADD  = 3'b000;  // ADD/SUB
  localparam fn3_t SLL  = 3'b001;
  localparam fn3_t SLT  = 3'b010;
  localparam fn3_t SLTU = 3'b011;
  localparam fn3_t XOR  = 3'b100;
  localparam fn3_t SR   = 3'b101;  // SRL/SRA by f7b5
  localparam fn3_t OR   = 3'b110;
  localparam fn3_t AND  = 3'b111;

  // Load funct3 codes
  localparam fn3_t LB   = 3'b000;
  localparam fn3_t LH   = 3'b001;
  localparam fn3_t LW   = 3'b010;
  localparam fn3_t LBU  = 3'b100;
  localparam fn3_t LHU  = 3'b101;

endpackage: riscv_isa_pkg

`default_nettype wire

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module r5p_wb_tb -f flist.f \
  -o r5p_wb_sim
./obj_dir/r5p_wb_sim

// File: verification/r5p_wb_props.sv
`timescale 1ns/1ps
`default_nettype none

module r5p_wb_props
  import riscv_isa_pkg::*;
(
  input wire logic     clk,
  input wire logic     rst,
  input wire logic     cmd_req,
  input wire logic     cmd_ack,
  input wire logic     cmd_err,
  input wire logic     mem_req,
  input wire logic     mem_ack,
  input wire logic     wen,
  input wire gpr_adr_t adr
);

  // Command handshake
  ack_needs_req: assert property (@(posedge clk) disable iff (rst)
    $rose(cmd_ack) |-> cmd_req)
    else $error("cmd_ack rose while cmd_req was low");

  // GPR write pulse
  wen_one_cycle: assert property (@(posedge clk) disable iff (rst) wen |=> !wen)
    else $error("wen held longer than one cycle");
  wen_not_x0: assert property (@(posedge clk) disable iff (rst) wen |-> (adr != '0))
    else $error("write to x0");

  // Memory request held until ack or abandon
  mem_req_held: assert property (@(posedge clk) disable iff (rst)
    (mem_req && !mem_ack) |=> (mem_req || cmd_err))
    else $error("mem_req dropped without ack or error");

  wen_no_err: assert property (@(posedge clk) disable iff (rst) !(wen && cmd_err))
    else $error("wen together with cmd_err");

endmodule: r5p_wb_props

bind r5p_wb_top r5p_wb_props props0 (.*);

`default_nettype wire

// File: verification/r5p_wb_tb.sv
`timescale 1ns/1ps
`default_nettype none

module r5p_wb_tb
  import riscv_isa_pkg::*;
();

  localparam int CLK_PER = 4;    // ns
  localparam int TMO_CYC = 16;
  localparam int HOLE    = 63;   // Word index the memory never acks
  localparam int MAX_CMD = 200;  // Watchdog budget in commands

  // Expected write-back of one command
  typedef struct packed {
    logic     err;
    logic     wr;
    gpr_adr_t rd;
    word_t    data;
  } wb_exp_t;

  logic        clk;
  logic        rst;
  logic        cmd_req;
  op32_op62_et cmd_opc;
  fn3_t        cmd_fn3;
  logic        cmd_f7b5;
  gpr_adr_t    cmd_rd;
  word_t       cmd_rs1, cmd_rs2, cmd_imm, cmd_pc;
  logic        cmd_ack, cmd_err;
  logic        mem_req, mem_ack;
  word_t       mem_adr, mem_rdata;
  logic        wen;
  gpr_adr_t    adr;
  word_t       dat;

  word_t       mem [64];  // Data memory model
  wb_exp_t     want;      // Expectation for the command in flight
  word_t       ld_adr;    // Word address of a load in flight
  int          n_cmd;
  int          n_ack;

  r5p_wb_top #(.XLEN(32), .TMO_CYC(TMO_CYC)) dut0 (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PER / 2) clk = ~clk;
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      $display("tests failed");
      $fatal(1, "Mismatch on %s", name);
    end
  endtask

  function automatic word_t rand_imm();
    word_t t;
    t = $urandom;
    return {{20{t[11]}}, t[11:0]};  // 12-bit immediate, sign extended
  endfunction

  // Expected result from the ISA rules and the model memory
  function automatic wb_exp_t predict_wb(op32_op62_et opc, fn3_t fn3, logic f7b5,
                                         gpr_adr_t rd, word_t rs1, word_t rs2,
                                         word_t imm, word_t pc);
    wb_exp_t            r;
    word_t              b;
    word_t              ea;
    word_t              w;
    logic signed [31:0] sra;
    r    = '0;
    r.rd = rd;
    case (opc)
      LUI:       r.data = imm;
      AUIPC:     r.data = pc + imm;
      JAL, JALR: r.data = pc + 32'd4;  // Link address
      OP, OP_IMM: begin
        b = (opc == OP) ? rs2 : imm;
        case (fn3)
          ADD:  r.data = (opc == OP && f7b5) ? rs1 - b : rs1 + b;
          SLL:  r.data = rs1 << b[4:0];
          SLT:  r.data = {31'd0, ($signed(rs1) < $signed(b))};
          SLTU: r.data = {31'd0, (rs1 < b)};
          XOR:  r.data = rs1 ^ b;
          SR: begin
            sra    = $signed(rs1) >>> b[4:0];
            r.data = f7b5 ? word_t'(sra) : (rs1 >> b[4:0]);
          end
          OR:   r.data = rs1 | b;
          default: r.data = rs1 & b;
        endcase
      end
      LOAD: begin
        ea = rs1 + imm;
        if (ea[7:2] == 6'(HOLE)) begin
          r.err = 1'b1;  // Never acked, ends in timeout
        end else begin
          w = mem[ea[7:2]] >> (8 * ea[1:0]);
          case (fn3)
            LB:      r.data = {{24{w[7]}}, w[7:0]};
            LH:      r.data = {{16{w[15]}}, w[15:0]};
            LBU:     r.data = {24'd0, w[7:0]};
            LHU:     r.data = {16'd0, w[15:0]};
            default: r.data = w;
          endcase
        end
      end
      default: r.err = 1'b1;  // Unsupported opcode
    endcase
    r.wr = !r.err && (rd != 5'd0);
    return r;
  endfunction

  // One full four-phase command
  task automatic issue_cmd(op32_op62_et opc, fn3_t fn3, logic f7b5, gpr_adr_t rd,
                           word_t rs1, word_t rs2, word_t imm, word_t pc);
    int lat;
    lat    = 0;
    want   = predict_wb(opc, fn3, f7b5, rd, rs1, rs2, imm, pc);
    ld_adr = (rs1 + imm) & ~32'd3;  // Effective address, word aligned
    @(posedge clk);
    #0.5;
    cmd_opc  = opc;
    cmd_fn3  = fn3;
    cmd_f7b5 = f7b5;
    cmd_rd   = rd;
    cmd_rs1  = rs1;
    cmd_rs2  = rs2;
    cmd_imm  = imm;
    cmd_pc   = pc;
    cmd_req  = 1'b1;
    n_cmd++;
    do begin
      @(negedge clk);
      lat++;
    end while (!cmd_ack);
    // Sampling edge, ISSUE edge, then ack: third negedge after the drive
    if (!want.err && opc != LOAD) check_value("cmd_ack_cycles", lat, 3);
    @(posedge clk);
    #0.5 cmd_req = 1'b0;
    do begin
      @(negedge clk);
    end while (cmd_ack);
  endtask

  ////////////////////
  // Memory model
  ////////////////////

  initial begin : mem_model
    int dly;
    forever begin
      @(negedge clk);
      if (mem_req) begin
        check_value("mem_adr", mem_adr, ld_adr);
        if (mem_adr[7:2] != 6'(HOLE)) begin
          dly = $urandom_range(3);
          repeat (dly) @(posedge clk);
          @(posedge clk);
          #0.5;
          mem_rdata = mem[mem_adr[7:2]];
          mem_ack   = 1'b1;
        end
        do begin
          @(negedge clk);
        end while (mem_req);  // Release, or timeout on the hole
        @(posedge clk);
        #0.5;
        mem_ack   = 1'b0;
        mem_rdata = '0;
      end
    end
  end

  ////////////////////
  // Monitor
  ////////////////////

  initial begin : monitor
    logic ack_q;
    ack_q = 1'b0;
    forever begin
      @(negedge clk);
      if (!rst) begin
        if (cmd_ack && !ack_q) begin  // End of a command
          n_ack++;
          check_value("cmd_err", cmd_err, want.err);
          check_value("wen", wen, want.wr);
          if (want.wr) begin
            check_value("adr", adr, want.rd);
            check_value("dat", dat, want.data);
          end
        end else begin
          check_value("wen", wen, 1'b0);  // No write outside the ack rise
        end
      end
      ack_q = cmd_ack;
    end
  end

  initial begin : watchdog
    #(MAX_CMD * (TMO_CYC + 20) * CLK_PER);
    $display("Watchdog expired, the run hung");
    $display("tests failed");
    $fatal(1, "Timeout");
  end

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin : main
    int          i;
    int          k;
    op32_op62_et op;
    fn3_t        fn;
    word_t       ea;
    word_t       imm;
    void'($urandom(4230));
    rst       = 1'b1;
    cmd_req   = 1'b0;
    cmd_opc   = OP;
    cmd_fn3   = '0;
    cmd_f7b5  = 1'b0;
    cmd_rd    = '0;
    cmd_rs1   = '0;
    cmd_rs2   = '0;
    cmd_imm   = '0;
    cmd_pc    = '0;
    mem_ack   = 1'b0;
    mem_rdata = '0;
    n_cmd     = 0;
    n_ack     = 0;
    for (i = 0; i < 64; i++) begin
      mem[i] = {8'(i * 37), 8'(~i), 8'(i ^ 8'hc3), 8'(i + 8'h80)};  // Mixed sign bits
    end
    repeat (10) @(posedge clk);
    #0.5 rst = 1'b0;

    // ALU ops, rd zero included
    repeat (60) begin
      op = ($urandom_range(1) == 0) ? OP : OP_IMM;
      issue_cmd(op, fn3_t'($urandom_range(7)), 1'($urandom_range(1)),
                gpr_adr_t'($urandom_range(31)), $urandom, $urandom, rand_imm(), $urandom);
    end
    issue_cmd(OP, ADD, 1'b0, 5'd0, $urandom, $urandom, rand_imm(), $urandom);

    // Upper immediate and jumps
    issue_cmd(LUI, '0, 1'b0, 5'd3, $urandom, $urandom, $urandom & 32'hffff_f000, $urandom);
    issue_cmd(AUIPC, '0, 1'b0, 5'd4, $urandom, $urandom, $urandom & 32'hffff_f000, $urandom);
    issue_cmd(JAL, '0, 1'b0, 5'd1, $urandom, $urandom, rand_imm(), $urandom & ~32'd3);
    issue_cmd(JALR, '0, 1'b0, 5'd5, $urandom, $urandom, rand_imm(), $urandom & ~32'd3);

    // Aligned loads of every width
    repeat (60) begin
      k = $urandom_range(4);
      case (k)
        0:       fn = LB;
        1:       fn = LBU;
        2:       fn = LH;
        3:       fn = LHU;
        default: fn = LW;
      endcase
      ea = ($urandom & 32'hffff_ff00) | (32'($urandom_range(62)) << 2);
      if (fn == LB || fn == LBU) ea = ea | 32'($urandom_range(3));
      else if (fn == LH || fn == LHU) ea = ea | (32'($urandom_range(1)) << 1);
      imm = rand_imm();
      issue_cmd(LOAD, fn, 1'b0, gpr_adr_t'($urandom_range(31)), ea - imm, $urandom, imm,
                $urandom);
    end

    // Hole address times out, next command still works
    imm = rand_imm();
    issue_cmd(LOAD, LW, 1'b0, 5'd7, (HOLE << 2) - imm, $urandom, imm, $urandom);
    issue_cmd(LUI, '0, 1'b0, 5'd8, $urandom, $urandom, 32'h1234_5000, $urandom);

    // Unsupported opcode (SYSTEM)
    issue_cmd(op32_op62_et'(5'b11_100), '0, 1'b0, 5'd9, $urandom, $urandom, rand_imm(),
              $urandom);
    issue_cmd(OP, XOR, 1'b0, 5'd10, $urandom, $urandom, rand_imm(), $urandom);

    repeat (4) @(posedge clk);
    check_value("ack_count", n_ack, n_cmd);
    $display("all tests passed");
    $finish;
  end

endmodule: r5p_wb_tb

`default_nettype wire
